// ==== fetch_top.f ====
+incdir+include
logic/ibus_pkg.sv
logic/fetch_pkg.sv
logic/ibus_if.sv
logic/fetch_pc_gen.sv
logic/fetch_stage.sv
logic/ibus_arbiter.sv
logic/insn_mem.sv
logic/fetch_top.sv
testbench/fetch_checker.sv
testbench/fetch_tb.sv

// ==== testbench/fetch_tb.sv ====
// Testbench of the instruction fetch front end
// Preloads the memory through the loader port, then runs sequential
// fetch, fault regions, freeze, flush and loader contention. Every
// delivery is checked against a shadow memory, the region map and a model PC
`timescale 1ns/10ps
`include "fetch_defs.svh"

module fetch_tb;

	logic        clk;
	logic        rst_i;
	logic        freeze_i;
	logic        flush_i;
	logic [31:0] flush_pc_i;
	logic        load_we_i;
	logic [31:0] load_adr_i;
	logic [31:0] load_dat_i;
	logic [31:0] insn_o;
	logic [31:0] pc_o;
	logic        insn_valid_o;
	logic        exc_itlb;
	logic        exc_immu;
	logic        exc_bus;

	// Model state
	logic [31:0] shadow [`FETCH_MEM_WORDS];
	logic [31:0] model_pc;
	int          deliv_count;
	int          check_count;
	int          err_count;
	int          timeout_count;

	fetch_top u_dut (
		.clk                (clk),
		.rst_i              (rst_i),
		.freeze_i           (freeze_i),
		.flush_i            (flush_i),
		.flush_pc_i         (flush_pc_i),
		.load_we_i          (load_we_i),
		.load_adr_i         (load_adr_i),
		.load_dat_i         (load_dat_i),
		.insn_o             (insn_o),
		.pc_o               (pc_o),
		.insn_valid_o       (insn_valid_o),
		.except_itlbmiss_o  (exc_itlb),
		.except_immufault_o (exc_immu),
		.except_ibuserr_o   (exc_bus)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////
	// Model helpers
	////////////////////

	// Bits 11:10 pick the region, any bit above 11 means absent
	function automatic logic [1:0] region_of(input logic [31:0] adr);
		if (adr[31:12] != 20'd0)
			return 2'b11;
		return adr[11:10];
	endfunction

	task automatic check_val(input logic [31:0] act, input logic [31:0] exp,
			input string what);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("ERR t=%0t: %s, got %h expected %h", $time, what, act, exp);
		end
	endtask

	// One delivery against the model PC
	task automatic check_delivery();
		logic [31:0] exp_insn;
		logic [2:0]  exp_exc;
		exp_insn = `FETCH_NOP;
		case (region_of(model_pc))
			2'b00: begin
				exp_insn = shadow[model_pc[9:2]];
				exp_exc  = 3'b000;
			end
			2'b01: exp_exc = 3'b100;
			2'b10: exp_exc = 3'b010;
			default: exp_exc = 3'b001;
		endcase
		check_val(pc_o, model_pc, "delivered PC");
		check_val(insn_o, exp_insn, "delivered instruction");
		check_val({exc_itlb, exc_immu, exc_bus}, exp_exc, "exception outputs");
	endtask

	// Sampled mid cycle, well away from the drive edge
	always @(negedge clk) begin
		if (!rst_i) begin
			if (flush_i) begin
				check_val(insn_valid_o, 1'b0, "valid during flush");
				check_val(insn_o, `FETCH_NOP, "bubble during flush");
				model_pc = {flush_pc_i[31:2], 2'b00};
			end else if (freeze_i) begin
				check_val(insn_valid_o, 1'b0, "valid during freeze");
			end else if (insn_valid_o) begin
				check_delivery();
				model_pc = model_pc + 32'd4;
				deliv_count++;
			end
		end
	end

	////////////////////
	// Stimulus tasks
	////////////////////

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	// Single cycle loader strobe; writes outside memory are lost
	task automatic load_word(input logic [31:0] adr, input logic [31:0] dat);
		load_we_i  = 1'b1;
		load_adr_i = adr;
		load_dat_i = dat;
		if (region_of(adr) == 2'b00)
			shadow[adr[9:2]] = dat;
		next_cycle();
		load_we_i = 1'b0;
	endtask

	task automatic flush_to(input logic [31:0] target);
		flush_i    = 1'b1;
		flush_pc_i = target;
		next_cycle();
		flush_i = 1'b0;
	endtask

	task automatic end_run();
		int asrt_fails;
		asrt_fails = u_dut.u_stage.u_checker.fail_count;
		$display("Summary: %0d checks, %0d delivered, %0d errors, %0d timeouts, %0d asserts",
			check_count, deliv_count, err_count, timeout_count, asrt_fails);
		if (err_count == 0 && timeout_count == 0 && asrt_fails == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	// Bounded wait for n more deliveries
	task automatic wait_deliveries(input int n, input int limit);
		int target;
		int cycles;
		target = deliv_count + n;
		cycles = 0;
		while (deliv_count < target && cycles < limit) begin
			next_cycle();
			cycles++;
		end
		if (deliv_count < target) begin
			$display("Timeout: only %0d of %0d instructions delivered within %0d cycles",
				n - (target - deliv_count), n, limit);
			timeout_count++;
			end_run();
		end
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		logic [31:0] adr;
		logic [31:0] off;
		void'($urandom(32'h3ce5));
		rst_i         = 1'b1;
		freeze_i      = 1'b1;
		flush_i       = 1'b0;
		flush_pc_i    = '0;
		load_we_i     = 1'b0;
		load_adr_i    = '0;
		load_dat_i    = '0;
		model_pc      = `FETCH_RESET_PC;
		deliv_count   = 0;
		check_count   = 0;
		err_count     = 0;
		timeout_count = 0;
		repeat (8) @(posedge clk);
		#2;
		rst_i = 1'b0;

		// Preload under freeze so fetch stays parked
		for (int i = 0; i < `FETCH_MEM_WORDS; i++)
			load_word(32'(i) * 32'd4, $urandom);
		freeze_i = 1'b0;

		// Sequential fetch from the reset PC
		wait_deliveries(40, 400);

		// Fault regions, two deliveries each
		for (int k = 0; k < 12; k++) begin
			off = $urandom & 32'h0000_03fc;
			case (k % 3)
				0: adr = 32'h0000_0400 | off;
				1: adr = 32'h0000_0800 | off;
				default: adr = (k % 2) ? (32'h0000_0c00 | off)
					: (($urandom & 32'hffff_fffc) | 32'h0000_1000);
			endcase
			flush_to(adr);
			wait_deliveries(2, 40);
		end

		// Random freeze intervals
		flush_to($urandom & 32'h0000_01fc);
		for (int k = 0; k < 20; k++) begin
			repeat ($urandom % 6 + 1) next_cycle();
			freeze_i = 1'b1;
			repeat ($urandom % 8 + 1) next_cycle();
			freeze_i = 1'b0;
		end
		wait_deliveries(4, 40);

		// Flushes at random points, back to back included
		for (int k = 0; k < 16; k++) begin
			repeat ($urandom % 6) next_cycle();
			flush_to($urandom & 32'h0000_03fc);
		end
		wait_deliveries(3, 40);

		// Loader writes ahead of the fetch, some into a faulting alias
		flush_to(32'h0000_0000);
		for (int k = 0; k < 60; k++) begin
			if ($urandom % 2) begin
				adr = (model_pc + 32'd16 + ($urandom % 16) * 32'd4) & 32'h0000_03fc;
				if ($urandom % 8 == 0)
					adr = adr | 32'h0000_0400;
				load_word(adr, $urandom);
			end else begin
				next_cycle();
			end
		end
		wait_deliveries(30, 300);

		end_run();
	end

endmodule

// ==== testbench/fetch_checker.sv ====
// Assertions on the hold register of the fetch stage
// Bound into every fetch_stage instance; each failing property raises
// $error and bumps fail_count, which the testbench adds to its totals
`timescale 1ns/10ps

module fetch_checker (
	input logic       clk,
	input logic       rst_i,
	input logic       freeze_i,
	input logic       flush_i,
	input logic       drop_i,
	input logic       ack_i,
	input logic       err_i,
	input logic       saved_i,
	input logic       valid_i,
	input logic [2:0] exc_i
);

	int fail_count = 0;

	// Live response under freeze goes into the hold register
	save_on_freeze: assert property (@(posedge clk) disable iff (rst_i)
		(ack_i | err_i) && !drop_i && freeze_i && !flush_i && !saved_i |=> saved_i)
		else begin
			$error("hold register missed a response taken under freeze");
			fail_count++;
		end

	// Flush empties the hold register
	clear_on_flush: assert property (@(posedge clk) disable iff (rst_i)
		flush_i |=> !saved_i)
		else begin
			$error("hold register still set after a flush");
			fail_count++;
		end

	// No exception flags without a delivery
	exc_only_valid: assert property (@(posedge clk) disable iff (rst_i)
		!valid_i |-> (exc_i == 3'b000))
		else begin
			$error("exception flag raised without a valid instruction");
			fail_count++;
		end

endmodule

bind fetch_stage fetch_checker u_checker (
	.clk      (clk),
	.rst_i    (rst_i),
	.freeze_i (freeze_i),
	.flush_i  (flush_i),
	.drop_i   (drop_resp_i),
	.ack_i    (resp_ack_i),
	.err_i    (resp_err_i),
	.saved_i  (saved_q),
	.valid_i  (insn_valid_o),
	.exc_i    (exc_o)
);

// ==== logic/fetch_top.sv ====
// Top level of the instruction fetch front end
// Plain ports toward the pipeline and the program loader; inside, the
// PC generator and the loader share the instruction memory through the
// arbiter, and the fetch stage drives the decoder outputs
`timescale 1ns/10ps
`include "fetch_defs.svh"

module fetch_top import fetch_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 freeze_i,
	input  logic                 flush_i,
	input  logic [`FETCH_AW-1:0] flush_pc_i,
	input  logic                 load_we_i,
	input  logic [`FETCH_AW-1:0] load_adr_i,
	input  logic [31:0]          load_dat_i,
	output logic [31:0]          insn_o,
	output logic [`FETCH_AW-1:0] pc_o,
	output logic                 insn_valid_o,
	output logic                 except_itlbmiss_o,
	output logic                 except_immufault_o,
	output logic                 except_ibuserr_o
);

	ibus_if if_fetch ();
	ibus_if if_load ();
	ibus_if if_mem ();

	logic       drop_resp;
	fetch_exc_t exc;

	// Loader port, single cycle write strobe
	assign if_load.req  = load_we_i;
	assign if_load.we   = load_we_i;
	assign if_load.adr  = load_adr_i;
	assign if_load.wdat = load_dat_i;

	fetch_pc_gen u_pc_gen (
		.clk         (clk),
		.rst_i       (rst_i),
		.freeze_i    (freeze_i),
		.flush_i     (flush_i),
		.flush_pc_i  (flush_pc_i),
		.drop_resp_o (drop_resp),
		.bus         (if_fetch)
	);

	// Response fields of the fetch port plus the held request address
	fetch_stage u_stage (
		.clk          (clk),
		.rst_i        (rst_i),
		.freeze_i     (freeze_i),
		.flush_i      (flush_i),
		.drop_resp_i  (drop_resp),
		.resp_ack_i   (if_fetch.ack),
		.resp_err_i   (if_fetch.err),
		.resp_tag_i   (if_fetch.tag),
		.resp_dat_i   (if_fetch.rdat),
		.resp_adr_i   (if_fetch.adr),
		.insn_o       (insn_o),
		.pc_o         (pc_o),
		.insn_valid_o (insn_valid_o),
		.exc_o        (exc)
	);

	ibus_arbiter u_arbiter (
		.clk   (clk),
		.fetch (if_fetch),
		.load  (if_load),
		.mem   (if_mem)
	);

	insn_mem u_mem (
		.clk   (clk),
		.rst_i (rst_i),
		.bus   (if_mem)
	);

	// Exception flags out as separate pins
	assign except_itlbmiss_o  = exc.itlbmiss;
	assign except_immufault_o = exc.immufault;
	assign except_ibuserr_o   = exc.ibuserr;

endmodule

// ==== logic/insn_mem.sv ====
// Instruction memory with region decode
// Reads and writes the word array inside the memory region, answers
// every other region with err and a fault tag. The response (ack or
// err, rdat, tag) is registered and appears one cycle after acceptance
`timescale 1ns/10ps
`include "fetch_defs.svh"

module insn_mem import ibus_pkg::*; (
	input logic       clk,
	input logic       rst_i,
	ibus_if.responder bus
);

	localparam int unsigned idx_w   = $clog2(`FETCH_MEM_WORDS);
	localparam int unsigned rgn_lsb = `FETCH_REGION_LSB;

	logic [31:0]      mem_q [`FETCH_MEM_WORDS];
	logic [idx_w-1:0] idx;
	logic [1:0]       rgn;
	logic             hi_set;
	logic             in_mem;
	itag_e            tag_d;

	// Registered response
	logic             ack_q;
	logic             err_q;
	logic [31:0]      rdat_q;
	itag_e            tag_q;

	////////////////////
	// Region decode
	////////////////////

	// Word index below the region field
	assign idx    = bus.adr[idx_w+1:2];
	assign rgn    = bus.adr[rgn_lsb+1:rgn_lsb];
	// Anything above bit 11 is outside the map
	assign hi_set = |bus.adr[`FETCH_AW-1:rgn_lsb+2];

	always_comb begin
		if (hi_set) begin
			tag_d = itag_bus_error;
		end else begin
			case (rgn)
				`FETCH_RGN_MEM:       tag_d = itag_none;
				`FETCH_RGN_UNMAPPED:  tag_d = itag_tlb_miss;
				`FETCH_RGN_PROTECTED: tag_d = itag_page_fault;
				`FETCH_RGN_ABSENT:    tag_d = itag_bus_error;
				default:              tag_d = itag_bus_error;
			endcase
		end
	end

	assign in_mem = (tag_d == itag_none);

	////////////////////
	// Array and response
	////////////////////

	// Writes always ack, outside the memory region they are lost
	always_ff @(posedge clk) begin
		if (rst_i) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
		end else begin
			ack_q <= bus.req & (bus.we | in_mem);
			err_q <= bus.req & !bus.we & !in_mem;
		end
	end

	always_ff @(posedge clk) begin
		if (bus.req & bus.we & in_mem)
			mem_q[idx] <= bus.wdat;
		rdat_q <= mem_q[idx];
		tag_q  <= bus.we ? itag_none : tag_d;
	end

	assign bus.ack  = ack_q;
	assign bus.err  = err_q;
	assign bus.rdat = rdat_q;
	assign bus.tag  = tag_q;

endmodule

// ==== logic/ibus_arbiter.sv ====
// Fixed priority arbiter for the single instruction memory
// The loader strobe always takes the memory; the fetch request waits
// while the loader owns the bus or while its own response is in flight.
// The grant is registered so each response reaches its own requester
`timescale 1ns/10ps

module ibus_arbiter import ibus_pkg::*; (
	input logic       clk,
	ibus_if.responder fetch,
	ibus_if.responder load,
	ibus_if.requester mem
);

	logic         load_gnt;
	logic         fetch_gnt;
	logic         fetch_resp;
	logic         load_resp;
	ibus_master_e mst_q;

	// Response in this cycle belongs to the requester granted last edge
	assign fetch_resp = (mem.ack | mem.err) & (mst_q == mst_fetch);
	assign load_resp  = (mem.ack | mem.err) & (mst_q == mst_loader);

	// Loader first; fetch not re-forwarded while its answer is on the bus
	assign load_gnt  = load.req;
	assign fetch_gnt = fetch.req & !load.req & !fetch_resp;

	////////////////////
	// Request mux
	////////////////////

	assign mem.req  = load_gnt | fetch_gnt;
	assign mem.we   = load_gnt ? load.we   : fetch.we;
	assign mem.adr  = load_gnt ? load.adr  : fetch.adr;
	assign mem.wdat = load_gnt ? load.wdat : fetch.wdat;

	// Owner of the next response cycle
	always_ff @(posedge clk) begin
		mst_q <= load_gnt ? mst_loader : mst_fetch;
	end

	////////////////////
	// Response routing
	////////////////////

	// Data and tag shared, strobes steered
	assign fetch.rdat = mem.rdat;
	assign fetch.tag  = mem.tag;
	assign fetch.ack  = mem.ack & fetch_resp;
	assign fetch.err  = mem.err & fetch_resp;

	assign load.rdat  = mem.rdat;
	assign load.tag   = mem.tag;
	assign load.ack   = mem.ack & load_resp;
	assign load.err   = mem.err & load_resp;

endmodule

// ==== logic/fetch_stage.sv ====
// Fetch stage toward the decoder
// Presents the fetched instruction and its PC, holds a response that
// lands during a pipeline freeze and replays it when the freeze lifts,
// puts a NOP bubble in place of errored, dropped or flushed fetches and
// turns the fault tag into the three exception flags
`timescale 1ns/10ps
`include "fetch_defs.svh"

module fetch_stage
	import ibus_pkg::*;
	import fetch_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 freeze_i,
	input  logic                 flush_i,
	input  logic                 drop_resp_i,
	input  logic                 resp_ack_i,
	input  logic                 resp_err_i,
	input  itag_e                resp_tag_i,
	input  logic [31:0]          resp_dat_i,
	input  logic [`FETCH_AW-1:0] resp_adr_i,
	output logic [31:0]          insn_o,
	output logic [`FETCH_AW-1:0] pc_o,
	output logic                 insn_valid_o,
	output fetch_exc_t           exc_o
);

	logic                 resp_live;
	logic                 save_insn;
	logic [31:0]          resp_insn;
	logic [`FETCH_AW-1:0] resp_pc;
	fetch_exc_t           exc_dec;

	// Hold register
	logic                 saved_q;
	logic [31:0]          insn_q;
	logic [`FETCH_AW-1:0] adr_q;
	fetch_exc_t           exc_q;

	////////////////////
	// Live response
	////////////////////

	// Ack or err for the current path only
	assign resp_live = (resp_ack_i | resp_err_i) & !drop_resp_i;

	// Errored fetch becomes a bubble
	assign resp_insn = resp_ack_i ? resp_dat_i : `FETCH_NOP;
	assign resp_pc   = {resp_adr_i[`FETCH_AW-1:2], 2'b00};

	// Tag decode, one flag per faulting region
	always_comb begin
		exc_dec.itlbmiss  = resp_err_i & (resp_tag_i == itag_tlb_miss);
		exc_dec.immufault = resp_err_i & (resp_tag_i == itag_page_fault);
		exc_dec.ibuserr   = resp_err_i & (resp_tag_i == itag_bus_error);
	end

	////////////////////
	// Hold under freeze
	////////////////////

	// Only one response can land per freeze
	assign save_insn = resp_live & freeze_i & !saved_q & !flush_i;

	// Flush wins, then a new save, then release on the first unfrozen edge
	always_ff @(posedge clk) begin
		if (rst_i)
			saved_q <= 1'b0;
		else if (flush_i)
			saved_q <= 1'b0;
		else if (save_insn)
			saved_q <= 1'b1;
		else if (!freeze_i)
			saved_q <= 1'b0;
	end

	// Captured instruction, address and flags
	always_ff @(posedge clk) begin
		if (save_insn) begin
			insn_q <= resp_insn;
			adr_q  <= resp_pc;
			exc_q  <= exc_dec;
		end
	end

	////////////////////
	// Decoder side
	////////////////////

	// Saved entry first, otherwise the bus response
	assign insn_valid_o = !freeze_i & !flush_i & (saved_q | resp_live);
	assign pc_o         = saved_q ? adr_q : resp_pc;

	always_comb begin
		if (flush_i)
			insn_o = `FETCH_NOP;
		else if (saved_q)
			insn_o = insn_q;
		else if (resp_live)
			insn_o = resp_insn;
		else
			insn_o = `FETCH_NOP;
	end

	// Flags travel only with a valid delivery
	always_comb begin
		if (!insn_valid_o)
			exc_o = '0;
		else if (saved_q)
			exc_o = exc_q;
		else
			exc_o = exc_dec;
	end

endmodule

// ==== logic/fetch_pc_gen.sv ====
// Program counter and fetch sequencer
// Keeps one read outstanding on the instruction bus, steps the PC by 4
// on every completed fetch, stops issuing under freeze and restarts at
// the flush target, marking the abandoned response for the stage
`timescale 1ns/10ps
`include "fetch_defs.svh"

module fetch_pc_gen import fetch_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 freeze_i,
	input  logic                 flush_i,
	input  logic [`FETCH_AW-1:0] flush_pc_i,
	output logic                 drop_resp_o,
	ibus_if.requester            bus
);

	fetch_state_e         state_q;
	logic [`FETCH_AW-1:0] pc_q;
	logic                 drop_q;
	logic                 resp_done;

	// Response for the current PC, not the one abandoned by a flush
	assign resp_done = (bus.ack | bus.err) & !drop_q;

	// Read only; request held for the whole wait state
	assign bus.req  = (state_q == fs_wait_resp);
	assign bus.we   = 1'b0;
	assign bus.adr  = pc_q;
	assign bus.wdat = '0;

	// Single cycle, memory answers exactly one edge after acceptance
	assign drop_resp_o = drop_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= fs_idle;
			pc_q    <= `FETCH_RESET_PC;
			drop_q  <= 1'b0;
		end else begin
			drop_q <= flush_i;
			if (flush_i) begin
				// Restart at word aligned target
				pc_q    <= {flush_pc_i[`FETCH_AW-1:2], 2'b00};
				state_q <= freeze_i ? fs_hold : fs_wait_resp;
			end else begin
				case (state_q)
					fs_idle: begin
						state_q <= freeze_i ? fs_hold : fs_wait_resp;
					end
					fs_wait_resp: begin
						// Next sequential word, err included
						if (resp_done) begin
							pc_q <= pc_q + `FETCH_AW'(4);
							if (freeze_i)
								state_q <= fs_hold;
						end
					end
					fs_hold: begin
						if (!freeze_i)
							state_q <= fs_wait_resp;
					end
					default: begin
						state_q <= fs_idle;
					end
				endcase
			end
		end
	end

endmodule

// ==== logic/ibus_if.sv ====
// Instruction bus between requesters, the arbiter and the memory
// One request phase (req, we, adr, wdat) and one response phase
// (ack, err, rdat, tag) one cycle after the accepting edge
`timescale 1ns/10ps
`include "fetch_defs.svh"

interface ibus_if import ibus_pkg::*; ();

	// Request phase
	logic                 req;
	logic                 we;
	logic [`FETCH_AW-1:0] adr;
	logic [31:0]          wdat;

	// Response phase
	logic [31:0]          rdat;
	logic                 ack;
	logic                 err;
	itag_e                tag;

	// Side that starts transfers
	modport requester (
		output req, we, adr, wdat,
		input  rdat, ack, err, tag
	);

	// Side that answers them
	modport responder (
		input  req, we, adr, wdat,
		output rdat, ack, err, tag
	);

endinterface

// ==== logic/fetch_pkg.sv ====
// Types of the pipeline side of the fetch front end
// Imported by the PC generator, the fetch stage and the top level
package fetch_pkg;

	////////////////////
	// PC generator FSM
	////////////////////

	typedef enum logic [1:0] {
		// Out of reset, no request yet
		fs_idle      = 2'b00,
		// Request on the bus until ack or err
		fs_wait_resp = 2'b01,
		// Frozen, no request
		fs_hold      = 2'b10
	} fetch_state_e;

	////////////////////
	// Exception flags
	////////////////////

	// At most one bit set, and only with a valid delivery
	typedef struct packed {
		// Fetch from the unmapped region
		logic itlbmiss;
		// Fetch from the protected region
		logic immufault;
		// Fetch from the absent region
		logic ibuserr;
	} fetch_exc_t;

endpackage

// ==== logic/ibus_pkg.sv ====
// Types of the instruction bus
// Imported by the bus interface, the arbiter, the memory and the
// fetch stage; holds the fault tag and the requester identity
package ibus_pkg;

	////////////////////
	// Fault tag
	////////////////////

	// Returned with err, one code per faulting region
	typedef enum logic [1:0] {
		// Memory region, no fault
		itag_none       = 2'b00,
		// Unmapped region
		itag_tlb_miss   = 2'b01,
		// Protected region
		itag_page_fault = 2'b10,
		// Absent region or address above the map
		itag_bus_error  = 2'b11
	} itag_e;

	////////////////////
	// Requester identity
	////////////////////

	// Owner of the memory in a given cycle, used for response routing
	typedef enum logic {
		mst_fetch  = 1'b0,
		mst_loader = 1'b1
	} ibus_master_e;

endpackage

// ==== include/fetch_defs.svh ====
// Shared constants of the instruction fetch front end
// Include in every file that needs the address width, the reset PC,
// the bubble instruction or the memory map of the instruction memory
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Address and data width of the instruction bus
`define FETCH_AW 32

// Backing memory depth in 32-bit words
`define FETCH_MEM_WORDS 256

// First fetch address after reset
`define FETCH_RESET_PC 32'h0000_0000

// Bubble instruction, l.nop style encoding
`define FETCH_NOP 32'h1500_0000

// Region field sits in address bits 11:10
`define FETCH_REGION_LSB 10

// Region codes, valid only with all bits above the field clear
`define FETCH_RGN_MEM 2'b00
`define FETCH_RGN_UNMAPPED 2'b01
`define FETCH_RGN_PROTECTED 2'b10
`define FETCH_RGN_ABSENT 2'b11

`endif
